/* logic/afferent_pkg.sv */
package afferent_pkg;

    // plain vector types, widths that carry a meaning
    typedef logic [15:0] host_word_t;         // one host data word
    typedef logic [15:0] rate_t;              // afferent rate in pulses per second
    typedef logic [15:0] gain_t;              // Q8 gain, 256 is unity
    typedef logic [15:0] half_cnt_t;          // tick divider setting
    typedef logic signed [31:0] current_t;    // neuron input current and membrane
    typedef logic [15:0] count_t;             // spikes per 1 ms window
    typedef logic [15:0] trig_t;              // one load pulse per parameter register

    // trigger bit numbers on the host trigger vector
    localparam int TRIG_IA_GAIN   = 1;
    localparam int TRIG_IA_OFFSET = 3;
    localparam int TRIG_II_OFFSET = 6;
    localparam int TRIG_HALF_CNT  = 7;
    localparam int TRIG_II_GAIN   = 10;

    // register values after reset
    localparam rate_t     OFFSET_DEFAULT   = 16'd10;    // about the resting afferent rate
    localparam gain_t     GAIN_DEFAULT     = 16'd256;   // 1.0 in Q8
    localparam half_cnt_t HALF_CNT_DEFAULT = 16'd381;   // half real time on a 25 MHz clock

    // rate to current scaling
    localparam int GAIN_FRAC_BITS = 8;     // fraction bits of the gain
    localparam int CURRENT_SHIFT  = 6;     // integer rate to fixed point current

    // neuron model
    // threshold is 30 mV scaled by 1024
    localparam current_t THRESHOLD = 32'sd30720;
    localparam int LEAK_SHIFT = 4;         // leak is v/16 per tick

    // neuron ticks per 1 ms of simulated time
    localparam int TICKS_PER_MS = 128;
    localparam int TICK_CNT_W   = $clog2(TICKS_PER_MS);

endpackage

/* logic/trigger_params.sv */
`timescale 1ns/100ps

module trigger_params import afferent_pkg::*; (
    input  logic       ep50trig,
    input  logic       reset_global,
    input  trig_t      trig,          // one-cycle load pulses, one bit per register
    input  host_word_t word_lo,       // value for all 16-bit registers
    input  host_word_t word_hi,       // upper word, reserved for wider fields
    output rate_t      ia_offset,
    output gain_t      ia_gain,
    output rate_t      ii_offset,
    output gain_t      ii_gain,
    output half_cnt_t  half_cnt
);

    // every register listens to its own trigger bit only
    // several bits in one cycle load several registers from the same word
    // word_hi stays unconnected until a 32-bit field is added
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            ia_offset <= OFFSET_DEFAULT;
            ia_gain   <= GAIN_DEFAULT;      // unity gain
            ii_offset <= OFFSET_DEFAULT;
            ii_gain   <= GAIN_DEFAULT;
            half_cnt  <= HALF_CNT_DEFAULT;  // slow ticks until the host reloads
        end else begin
            // Ia channel
            if (trig[TRIG_IA_OFFSET]) begin
                ia_offset <= word_lo;
            end
            if (trig[TRIG_IA_GAIN]) begin
                ia_gain <= word_lo;          // Q8
            end

            // II channel
            if (trig[TRIG_II_OFFSET]) begin
                ii_offset <= word_lo;
            end
            if (trig[TRIG_II_GAIN]) begin
                ii_gain <= word_lo;          // Q8
            end

            // tick divider, used by tick_gen from its next compare
            if (trig[TRIG_HALF_CNT]) begin
                half_cnt <= word_lo;
            end
        end
    end

endmodule

/* logic/tick_gen.sv */
`timescale 1ns/100ps

module tick_gen import afferent_pkg::*; (
    input  logic      ep50trig,
    input  logic      reset_global,
    input  half_cnt_t half_cnt,      // divider limit, tick period is half_cnt+1
    output logic      neuron_tick,   // one cycle per neuron update
    output logic      ms_tick        // one cycle per simulated millisecond
);

    half_cnt_t             div_cnt;   // runs 0..half_cnt
    logic [TICK_CNT_W-1:0] tick_cnt;  // neuron ticks inside the current ms
    logic                  div_wrap;

    // >= so that a smaller half_cnt loaded mid-count wraps right away
    assign div_wrap = (div_cnt >= half_cnt);

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            div_cnt     <= '0;
            tick_cnt    <= '0;
            neuron_tick <= 1'b0;
            ms_tick     <= 1'b0;
        end else begin
            neuron_tick <= div_wrap;
            ms_tick     <= 1'b0;
            if (div_wrap) begin
                div_cnt <= '0;
                // last neuron tick of the window also carries the ms tick
                if (tick_cnt == TICK_CNT_W'(TICKS_PER_MS - 1)) begin
                    tick_cnt <= '0;
                    ms_tick  <= 1'b1;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/rate_to_current.sv */
`timescale 1ns/100ps

module rate_to_current import afferent_pkg::*; (
    input  logic     ep50trig,
    input  logic     reset_global,
    input  rate_t    rate,      // afferent rate, pps
    input  rate_t    offset,    // resting rate to remove
    input  gain_t    gain,      // Q8
    output current_t current    // registered neuron input current
);

    rate_t       rate_diff;     // rate above offset, clamped at 0
    logic [31:0] gained;        // 16x16 product, still Q8
    logic [31:0] scaled;

    // below the offset the channel is silent, no negative current
    assign rate_diff = (rate > offset) ? rate - offset : '0;

    assign gained = 32'(rate_diff) * 32'(gain);

    // drop the gain fraction first, then move to the current fixed point
    // max result is below 2^30 so it stays positive as a signed value
    assign scaled = (gained >> GAIN_FRAC_BITS) << CURRENT_SHIFT;

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            current <= '0;
        end else begin
            current <= current_t'(scaled);   // one cycle from rate or parameter
        end
    end

endmodule

/* logic/spiking_neuron.sv */
`timescale 1ns/100ps

module spiking_neuron import afferent_pkg::*; (
    input  logic     ep50trig,
    input  logic     reset_global,
    input  logic     neuron_tick,   // membrane update enable
    input  current_t current,       // input current, held between ticks
    output logic     spike          // one-cycle pulse after a crossing tick
);

    current_t v;         // membrane, always below threshold after an update
    current_t leak;
    current_t v_next;    // candidate membrane for this tick
    logic     fire;

    // leaky integrate
    assign leak   = v >>> LEAK_SHIFT;           // arithmetic, v/16
    assign v_next = v + current - leak;
    assign fire   = (v_next >= THRESHOLD);

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            v     <= '0;
            spike <= 1'b0;
        end else begin
            spike <= 1'b0;                      // pulse lasts one cycle
            if (neuron_tick) begin
                if (fire) begin
                    v     <= '0;                // reset to rest on firing
                    spike <= 1'b1;
                end else begin
                    v <= v_next;
                end
            end
        end
    end

endmodule

/* logic/spike_counter.sv */
`timescale 1ns/100ps

module spike_counter import afferent_pkg::*; (
    input  logic   ep50trig,
    input  logic   reset_global,
    input  logic   spike,       // spike pulse from the neuron
    input  logic   ms_tick,     // window boundary
    output count_t count_out    // total of the last full window
);

    count_t run_cnt;    // spikes so far in this window
    count_t run_next;   // running count plus this cycle, saturated

    assign run_next = (spike && run_cnt != '1) ? run_cnt + 1'b1 : run_cnt;

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            run_cnt   <= '0;
            count_out <= '0;
        end else if (ms_tick) begin
            count_out <= run_next;   // a spike on the tick still counts here
            run_cnt   <= '0;
        end else begin
            run_cnt <= run_next;
        end
    end

endmodule

/* logic/afferent_rack.sv */
`timescale 1ns/100ps

module afferent_rack import afferent_pkg::*; (
    input  logic       ep50trig,
    input  logic       reset_global,
    input  trig_t      trig,       // host load pulses
    input  host_word_t word_lo,
    input  host_word_t word_hi,
    input  rate_t      rate_ia,    // Ia afferent rate, pps
    input  rate_t      rate_ii,    // II afferent rate, pps
    output logic       spike_ia,
    output logic       spike_ii,
    output count_t     count_ia,   // Ia spikes in the last ms
    output count_t     count_ii,
    output logic       ms_tick
);

    rate_t     ia_offset;
    gain_t     ia_gain;
    rate_t     ii_offset;
    gain_t     ii_gain;
    half_cnt_t half_cnt;
    logic      neuron_tick;
    current_t  ia_current;   // Ia neuron input
    current_t  ii_current;   // II neuron input

    // host parameters
    trigger_params params (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .trig         (trig),
        .word_lo      (word_lo),
        .word_hi      (word_hi),
        .ia_offset    (ia_offset),
        .ia_gain      (ia_gain),
        .ii_offset    (ii_offset),
        .ii_gain      (ii_gain),
        .half_cnt     (half_cnt)
    );

    tick_gen ticks (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .half_cnt     (half_cnt),
        .neuron_tick  (neuron_tick),
        .ms_tick      (ms_tick)      // also the window boundary for both counters
    );

    // Ia path
    rate_to_current ia_current_conv (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .rate         (rate_ia),
        .offset       (ia_offset),
        .gain         (ia_gain),
        .current      (ia_current)
    );

    spiking_neuron ia_neuron (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .neuron_tick  (neuron_tick),
        .current      (ia_current),
        .spike        (spike_ia)
    );

    spike_counter ia_counter (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .spike        (spike_ia),
        .ms_tick      (ms_tick),
        .count_out    (count_ia)
    );

    // II path, same blocks with its own parameters
    rate_to_current ii_current_conv (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .rate         (rate_ii),
        .offset       (ii_offset),
        .gain         (ii_gain),
        .current      (ii_current)
    );

    spiking_neuron ii_neuron (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .neuron_tick  (neuron_tick),
        .current      (ii_current),
        .spike        (spike_ii)
    );

    spike_counter ii_counter (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .spike        (spike_ii),
        .ms_tick      (ms_tick),
        .count_out    (count_ii)
    );

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic ep50trig,       // 40 ns period
    output logic reset_global    // high for the first two rising edges
);

    always #20 ep50trig = ~ep50trig;

    initial begin
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        repeat (2) @(posedge ep50trig);
        @(negedge ep50trig);          // release away from the active edge
        reset_global = 1'b0;
    end

endmodule

/* verification/afferent_rack_props.sv */
`timescale 1ns/100ps

module afferent_rack_props import afferent_pkg::*; (
    input logic   ep50trig,
    input logic   reset_global,
    input logic   neuron_tick,
    input logic   ms_tick,
    input logic   spike_ia,
    input logic   spike_ii,
    input count_t count_ia,
    input count_t count_ii
);

    int assert_errors = 0;    // read by the testbench for its verdict

    // the ms tick always rides on a neuron tick
    ms_on_neuron_tick: assert property (@(posedge ep50trig) disable iff (reset_global)
        ms_tick |-> neuron_tick)
        else begin
            assert_errors = assert_errors + 1;
            $error("ms_tick high without neuron_tick");
        end

    // spikes are one-cycle pulses
    ia_single_pulse: assert property (@(posedge ep50trig) disable iff (reset_global)
        spike_ia |=> !spike_ia)
        else begin
            assert_errors = assert_errors + 1;
            $error("spike_ia longer than one cycle");
        end

    ii_single_pulse: assert property (@(posedge ep50trig) disable iff (reset_global)
        spike_ii |=> !spike_ii)
        else begin
            assert_errors = assert_errors + 1;
            $error("spike_ii longer than one cycle");
        end

    // first edge out of reset sees everything idle
    idle_after_reset: assert property (@(posedge ep50trig) $fell(reset_global) |->
        (!spike_ia && !spike_ii && !ms_tick && count_ia == '0 && count_ii == '0))
        else begin
            assert_errors = assert_errors + 1;
            $error("outputs active right after reset");
        end

endmodule

bind afferent_rack afferent_rack_props rack_props (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .neuron_tick  (neuron_tick),
    .ms_tick      (ms_tick),
    .spike_ia     (spike_ia),
    .spike_ii     (spike_ii),
    .count_ia     (count_ia),
    .count_ii     (count_ii)
);

/* verification/tb_afferent_rack.sv */
`timescale 1ns/100ps

module tb_afferent_rack import afferent_pkg::*; ();

    localparam int unsigned RAND_SEED = 94122;
    localparam int MODE_HOLD  = 0;   // inputs stay put
    localparam int MODE_PARAM = 1;   // random trigger pulses and words
    localparam int MODE_RATES = 2;   // random rates only
    localparam int MODE_QUIET = 3;   // rates at or below the offsets
    localparam int MODE_II    = 4;   // only the II channel moves
    localparam int QUIET_OFFSET = 800;
    // 1 + 4*3 + 6 + 4 + 8 + 4 windows, half_cnt never above 4
    localparam int WINDOWS = 35;
    localparam int TEST_CYCLES = WINDOWS * TICKS_PER_MS * 5 + 200;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

    logic ep50trig, reset_global;
    trig_t trig;
    host_word_t word_lo, word_hi;
    rate_t rate_ia, rate_ii;
    logic spike_ia, spike_ii, ms_tick;
    count_t count_ia, count_ii;

    // reference model state, index 0 is Ia and 1 is II
    rate_t m_off[2];
    gain_t m_gain[2];
    half_cnt_t m_half, m_div;
    int m_tcnt;
    logic m_ntick, m_ms;
    current_t m_cur[2];
    current_t m_v[2];                  // membranes
    logic m_spk[2];
    count_t m_run[2], m_cnt[2];
    logic model_live = 1'b0;           // set once the first reset edge is seen
    int cycle = 0;
    int checks = 0;
    int value_errors = 0;

    tb_clock clk_src (.ep50trig(ep50trig), .reset_global(reset_global));

    afferent_rack uut (
        .ep50trig(ep50trig), .reset_global(reset_global), .trig(trig),
        .word_lo(word_lo), .word_hi(word_hi), .rate_ia(rate_ia), .rate_ii(rate_ii),
        .spike_ia(spike_ia), .spike_ii(spike_ii), .count_ia(count_ia),
        .count_ii(count_ii), .ms_tick(ms_tick)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $urandom % n;
    endfunction

    // offset removal, Q8 gain, then current scaling
    function automatic current_t expected_current(input rate_t rate, input rate_t offset,
                                                  input gain_t gain);
        longint product;
        if (rate <= offset) return '0;
        product = (longint'(rate) - longint'(offset)) * longint'(gain);
        return current_t'((product >> GAIN_FRAC_BITS) << CURRENT_SHIFT);
    endfunction

    task automatic reset_model();
        m_half = HALF_CNT_DEFAULT;
        m_div = '0;
        m_tcnt = 0;
        m_ntick = 1'b0;
        m_ms = 1'b0;
        for (int c = 0; c < 2; c++) begin
            m_off[c] = OFFSET_DEFAULT;
            m_gain[c] = GAIN_DEFAULT;
            m_cur[c] = '0;
            m_v[c] = '0;
            m_spk[c] = 1'b0;
            m_run[c] = '0;
            m_cnt[c] = '0;
        end
    endtask

    // updated back to front so every stage sees last cycle's values
    task automatic step_model();
        count_t run_nxt;
        current_t cand;
        for (int c = 0; c < 2; c++) begin
            run_nxt = (m_spk[c] && m_run[c] != 16'hFFFF) ? m_run[c] + 16'd1 : m_run[c];
            if (m_ms) begin
                m_cnt[c] = run_nxt;          // spike on the tick still counts
                m_run[c] = '0;
            end else begin
                m_run[c] = run_nxt;
            end
            m_spk[c] = 1'b0;
            if (m_ntick) begin
                cand = m_v[c] + m_cur[c] - (m_v[c] >>> LEAK_SHIFT);
                if (cand >= THRESHOLD) begin
                    m_v[c] = '0;
                    m_spk[c] = 1'b1;
                end else begin
                    m_v[c] = cand;
                end
            end
        end
        m_cur[0] = expected_current(rate_ia, m_off[0], m_gain[0]);
        m_cur[1] = expected_current(rate_ii, m_off[1], m_gain[1]);
        m_ms = 1'b0;
        m_ntick = (m_div >= m_half);         // divider wrap
        if (m_ntick) begin
            m_div = '0;
            if (m_tcnt == TICKS_PER_MS - 1) begin
                m_tcnt = 0;
                m_ms = 1'b1;
            end else begin
                m_tcnt++;
            end
        end else begin
            m_div = m_div + 16'd1;
        end
        if (trig[TRIG_IA_OFFSET]) m_off[0] = word_lo;
        if (trig[TRIG_IA_GAIN]) m_gain[0] = word_lo;
        if (trig[TRIG_II_OFFSET]) m_off[1] = word_lo;
        if (trig[TRIG_II_GAIN]) m_gain[1] = word_lo;
        if (trig[TRIG_HALF_CNT]) m_half = word_lo;
    endtask

    always @(posedge ep50trig) begin
        cycle++;
        if (reset_global) begin
            reset_model();
            model_live = 1'b1;
        end else begin
            step_model();
        end
    end

    // outputs are settled at the falling edge
    always @(negedge ep50trig) begin
        if (model_live) begin
            check_value("spike_ia", spike_ia, m_spk[0]);
            check_value("spike_ii", spike_ii, m_spk[1]);
            check_value("ms_tick", ms_tick, m_ms);
            check_value("count_ia", count_ia, m_cnt[0]);
            check_value("count_ii", count_ii, m_cnt[1]);
        end
    end

    task automatic load_param(input int bit_no, input int unsigned value);
        @(negedge ep50trig);
        trig = '0;
        trig[bit_no] = 1'b1;
        word_lo = host_word_t'(value);
        word_hi = host_word_t'($urandom);     // ignored by the DUT
        @(negedge ep50trig);
        trig = '0;
    endtask

    task automatic drive_stimulus(input int mode);
        trig = '0;                           // pulses last one cycle
        case (mode)
            MODE_PARAM: begin
                if (rand_below(8) == 0) begin
                    trig = trig_t'($urandom);
                    word_lo = trig[TRIG_HALF_CNT] ? host_word_t'(1 + rand_below(4))
                                                  : host_word_t'(rand_below(1024));
                    word_hi = host_word_t'($urandom);
                end
                if (rand_below(64) == 0) begin
                    rate_ia = rate_t'(rand_below(1501));
                    rate_ii = rate_t'(rand_below(1501));
                end
            end
            MODE_RATES: if (rand_below(32) == 0) begin
                rate_ia = rate_t'(rand_below(1201));
                rate_ii = rate_t'(rand_below(1201));
            end
            MODE_QUIET: if (rand_below(32) == 0) begin
                rate_ia = rate_t'(rand_below(QUIET_OFFSET + 1));
                rate_ii = rate_t'(rand_below(QUIET_OFFSET + 1));
            end
            MODE_II: if (rand_below(16) == 0) begin
                case (rand_below(3))
                    0: begin
                        trig[TRIG_II_OFFSET] = 1'b1;
                        word_lo = host_word_t'(rand_below(200));
                    end
                    1: begin
                        trig[TRIG_II_GAIN] = 1'b1;
                        word_lo = host_word_t'(rand_below(1024));
                    end
                    default: rate_ii = rate_t'(rand_below(1201));
                endcase
            end
            default: ;
        endcase
    endtask

    // runs until n ms ticks, last_gap is the cycle distance of the last two
    task automatic run_ms(input int n, input int mode, input logic quiet_check,
                          output int last_gap);
        int seen;
        int gap;
        seen = 0;
        gap = 0;
        last_gap = 0;
        while (seen < n) begin
            @(negedge ep50trig);
            gap++;
            if (quiet_check) begin
                check_value("spike_ia quiet", spike_ia, 0);
                check_value("spike_ii quiet", spike_ii, 0);
            end
            if (ms_tick) begin
                seen++;
                last_gap = gap;
                gap = 0;
                if (quiet_check) begin
                    check_value("count_ia quiet", count_ia, 0);
                    check_value("count_ii quiet", count_ii, 0);
                end
            end
            drive_stimulus(mode);
        end
    endtask

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int gap;
        int h;
        trig = '0;
        word_lo = '0;
        word_hi = '0;
        rate_ia = '0;
        rate_ii = '0;
        void'($urandom(RAND_SEED));
        wait (reset_global === 1'b0);
        @(negedge ep50trig);
        // idle right after reset
        check_value("spike_ia reset", spike_ia, 0);
        check_value("spike_ii reset", spike_ii, 0);
        check_value("ms_tick reset", ms_tick, 0);
        check_value("count_ia reset", count_ia, 0);
        check_value("count_ii reset", count_ii, 0);
        load_param(TRIG_HALF_CNT, 2);          // short windows from here on
        run_ms(1, MODE_HOLD, 1'b0, gap);
        // ms interval follows half_cnt
        for (int k = 0; k < 4; k++) begin
            h = 1 + rand_below(4);
            rate_ia = rate_t'(rand_below(1501));
            rate_ii = rate_t'(rand_below(1501));
            load_param(TRIG_HALF_CNT, h);
            run_ms(3, MODE_HOLD, 1'b0, gap);
            check_value("ms_tick interval", gap, TICKS_PER_MS * (h + 1));
        end
        run_ms(6, MODE_PARAM, 1'b0, gap);
        // subthreshold, two windows to settle then silence
        // the count shown at the next tick still covers the load cycles
        load_param(TRIG_IA_OFFSET, QUIET_OFFSET);
        load_param(TRIG_II_OFFSET, QUIET_OFFSET);
        load_param(TRIG_IA_GAIN, 256 + rand_below(768));
        load_param(TRIG_II_GAIN, 256 + rand_below(768));
        rate_ia = rate_t'(rand_below(QUIET_OFFSET + 1));
        rate_ii = rate_t'(rand_below(QUIET_OFFSET + 1));
        run_ms(2, MODE_QUIET, 1'b0, gap);
        run_ms(2, MODE_QUIET, 1'b1, gap);
        // random rates and gains
        load_param(TRIG_IA_OFFSET, rand_below(101));
        load_param(TRIG_II_OFFSET, rand_below(101));
        load_param(TRIG_IA_GAIN, 128 + rand_below(896));
        load_param(TRIG_II_GAIN, 128 + rand_below(896));
        run_ms(8, MODE_RATES, 1'b0, gap);
        // II moves alone, Ia held
        run_ms(4, MODE_II, 1'b0, gap);
        $display("checks %0d, value errors %0d, assertion errors %0d",
                 checks, value_errors, uut.rack_props.assert_errors);
        if (value_errors == 0 && uut.rack_props.assert_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* all.f */
logic/afferent_pkg.sv
logic/trigger_params.sv
logic/tick_gen.sv
logic/rate_to_current.sv
logic/spiking_neuron.sv
logic/spike_counter.sv
logic/afferent_rack.sv
verification/tb_clock.sv
verification/afferent_rack_props.sv
verification/tb_afferent_rack.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the afferent_rack testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_afferent_rack \
    -f all.f \
    -Mdir obj_dir -o sim_afferent_rack \
    || { echo "build failed"; exit 1; }

# the run passes only if the pass line shows up in the output
./obj_dir/sim_afferent_rack | tee /dev/stderr | grep -qxF "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
